/* ime_settings.svh */
`ifndef IME_SETTINGS_SVH
`define IME_SETTINGS_SVH

`default_nettype none

// mv component widths, x covers -64..63 and y covers -32..31
`define IME_MV_WIDTH_X 7
`define IME_MV_WIDTH_Y 6

// usable window sits this far inside the full mv range
`define IME_WIN_MARGIN 4

// original block rows fetched before the search
`define IME_INIT_ROWS 32

// mv cost width and pixel depth
`define IME_C_MV_WIDTH 10
`define IME_PIXEL_WIDTH 8

`default_nettype wire

`endif

/* ime_geom_pkg.sv */
`include "ime_settings.svh"
`default_nettype none

package ime_geom_pkg;

  // signed mv components
  typedef logic signed [`IME_MV_WIDTH_X-1:0] mv_x_t;
  typedef logic signed [`IME_MV_WIDTH_Y-1:0] mv_y_t;

  // search positions, one bit of headroom over the mv
  typedef logic signed [`IME_MV_WIDTH_X:0] pos_x_t;
  typedef logic signed [`IME_MV_WIDTH_Y:0] pos_y_t;

  // pattern half-lengths
  typedef logic [`IME_MV_WIDTH_X-2:0] len_x_t;
  typedef logic [`IME_MV_WIDTH_Y-2:0] len_y_t;

  // slope of the pattern edge, vertical uses length y as is
  typedef enum logic [1:0] {
    SLOPE_HALF = 2'd0,
    SLOPE_ONE  = 2'd1,
    SLOPE_TWO  = 2'd2,
    SLOPE_VERT = 2'd3
  } slope_e;

  typedef struct packed {
    mv_x_t      center_x;
    mv_y_t      center_y;
    len_x_t     len_x;
    len_y_t     len_y;
    slope_e     slope;
    logic [5:0] qp;
  } ime_cfg_t;

endpackage

`default_nettype wire

/* ime_scan_pkg.sv */
`include "ime_settings.svh"
`default_nettype none

package ime_scan_pkg;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SETTLE = 2'd1,
    ST_INIT   = 2'd2,
    ST_BUSY   = 2'd3
  } scan_state_e;

  // also used for the snake direction, which is only down or up
  typedef enum logic [1:0] {
    REF_DOWN  = 2'd0,
    REF_UP    = 2'd1,
    REF_RIGHT = 2'd2
  } ref_dir_e;

  typedef struct packed {
    scan_state_e                        state;
    ime_geom_pkg::pos_x_t               cur_x;
    ime_geom_pkg::pos_y_t               cur_y;
    logic [$clog2(`IME_INIT_ROWS)-1:0]  init_row;
    ref_dir_e                           dir;
    // last point of a column
    logic                               turn;
  } scan_pos_t;

  typedef struct packed {
    logic       en;
    logic [5:0] x;
    logic [5:0] y;
  } ori_port_t;

  typedef struct packed {
    ref_dir_e                  dir;
    logic                      hor_en;
    logic [`IME_MV_WIDTH_X:0]  hor_x;
    logic [`IME_MV_WIDTH_Y:0]  hor_y;
    logic                      ver_en;
    // vertical port is transposed, x carries the row offset
    logic [`IME_MV_WIDTH_Y:0]  ver_x;
    logic [`IME_MV_WIDTH_X:0]  ver_y;
  } ref_port_t;

  typedef struct packed {
    logic                        valid;
    ime_geom_pkg::mv_x_t         mv_x;
    ime_geom_pkg::mv_y_t         mv_y;
    logic [`IME_C_MV_WIDTH-1:0]  cost;
  } mv_stat_t;

endpackage

`default_nettype wire

/* ime_cfg_regs.sv */
`default_nettype none

module ime_cfg_regs (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   start_i,
  input  logic                   idle_i,
  input  ime_geom_pkg::ime_cfg_t cfg_i,
  output ime_geom_pkg::ime_cfg_t cfg_o
);

  logic load;

  // a start outside idle belongs to no run
  assign load = start_i && idle_i;

  // ------------------------------
  // held search configuration
  // ------------------------------
  // stays fixed from settle through the last busy cycle, so the
  // inputs are free to move on once start is taken
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_o <= '0;
    end else if (load) begin
      cfg_o <= cfg_i;
    end
  end

endmodule

`default_nettype wire

/* ime_scan_ctrl.sv */
`include "ime_settings.svh"
`default_nettype none

module ime_scan_ctrl (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start_i,
  input  ime_geom_pkg::ime_cfg_t  cfg_i,
  output logic                    idle_o,
  output ime_scan_pkg::scan_pos_t pos_o,
  output logic                    done_o
);

  import ime_geom_pkg::*;
  import ime_scan_pkg::*;

  // half range minus margin, 60 for x and 28 for y
  localparam pos_x_t WIN_X = pos_x_t'((1 << (`IME_MV_WIDTH_X - 1)) - `IME_WIN_MARGIN);
  localparam pos_y_t WIN_Y = pos_y_t'((1 << (`IME_MV_WIDTH_Y - 1)) - `IME_WIN_MARGIN);
  localparam int LAST_ROW = `IME_INIT_ROWS - 1;

  scan_state_e state_q;
  scan_state_e state_d;

  pos_x_t                            cur_x_q;
  pos_y_t                            cur_y_q;
  logic [$clog2(`IME_INIT_ROWS)-1:0] row_q;
  ref_dir_e                          dir_q;

  pos_x_t sw_left;
  pos_x_t sw_right;
  pos_y_t sw_up;
  pos_y_t sw_down;
  pos_x_t pt_left;
  pos_x_t pt_right;
  pos_y_t pt_up;
  pos_y_t pt_down;
  pos_x_t abs_x;
  pos_x_t start_col;

  // two extra bits so the doubled slope edge cannot wrap
  logic signed [`IME_MV_WIDTH_X+1:0] sp_diff;
  logic signed [`IME_MV_WIDTH_X+1:0] sp_lim;

  logic reach_x;
  logic reach_up;
  logic reach_dn;
  logic reach_y;
  logic init_end;
  logic busy_end;

  // ------------------------------
  // boundaries
  // ------------------------------
  assign sw_right = WIN_X - cfg_i.center_x;
  assign sw_left  = -WIN_X - cfg_i.center_x;
  assign sw_down  = WIN_Y - cfg_i.center_y;
  assign sw_up    = -WIN_Y - cfg_i.center_y;

  assign pt_right = pos_x_t'(cfg_i.len_x);
  assign pt_left  = -pt_right;
  assign pt_down  = pos_y_t'(cfg_i.len_y);
  assign pt_up    = -pt_down;

  assign abs_x   = (cur_x_q < 0) ? -cur_x_q : cur_x_q;
  assign sp_diff = pt_right - abs_x;

  always_comb begin
    case (cfg_i.slope)
      SLOPE_HALF: sp_lim = sp_diff >>> 1;
      SLOPE_ONE:  sp_lim = sp_diff;
      SLOPE_TWO:  sp_lim = sp_diff <<< 1;
      default:    sp_lim = pt_down;
    endcase
  end

  assign start_col = (sw_left > pt_left) ? sw_left : pt_left;

  assign reach_x  = (cur_x_q >= sw_right) || (cur_x_q >= pt_right);
  assign reach_dn = (cur_y_q >= sw_down) || (cur_y_q >= pt_down) || (cur_y_q >= sp_lim);
  assign reach_up = (cur_y_q <= sw_up) || (cur_y_q <= pt_up) || (cur_y_q <= -sp_lim);
  assign reach_y  = (dir_q == REF_UP) ? reach_up : reach_dn;

  assign init_end = (int'(row_q) == LAST_ROW);
  assign busy_end = reach_x && reach_y;

  // ------------------------------
  // state machine
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_SETTLE;
        end
      end
      ST_SETTLE: state_d = ST_INIT;
      ST_INIT: begin
        if (init_end) begin
          state_d = ST_BUSY;
        end
      end
      default: begin
        if (busy_end) begin
          state_d = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= ST_IDLE;
      done_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_o  <= (state_q == ST_BUSY) && busy_end;
    end
  end

  // snake walk, one point per busy cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cur_x_q <= '0;
      cur_y_q <= '0;
      row_q   <= '0;
      dir_q   <= REF_DOWN;
    end else begin
      case (state_q)
        ST_SETTLE: begin
          cur_x_q <= start_col;
          cur_y_q <= '0;
          row_q   <= '0;
          dir_q   <= REF_DOWN;
        end
        ST_INIT: begin
          // wraps back to 0 on the last row
          row_q <= row_q + 1'b1;
        end
        ST_BUSY: begin
          if (reach_y) begin
            cur_x_q <= cur_x_q + pos_x_t'(1);
            dir_q   <= (dir_q == REF_UP) ? REF_DOWN : REF_UP;
          end else if (dir_q == REF_UP) begin
            cur_y_q <= cur_y_q - pos_y_t'(1);
          end else begin
            cur_y_q <= cur_y_q + pos_y_t'(1);
          end
        end
        default: begin
        end
      endcase
    end
  end

  assign idle_o = (state_q == ST_IDLE);

  always_comb begin
    pos_o.state    = state_q;
    pos_o.cur_x    = cur_x_q;
    pos_o.cur_y    = cur_y_q;
    pos_o.init_row = row_q;
    pos_o.dir      = dir_q;
    pos_o.turn     = (state_q == ST_BUSY) && reach_y;
  end

endmodule

`default_nettype wire

/* ime_ref_addr.sv */
`include "ime_settings.svh"
`default_nettype none

module ime_ref_addr (
  input  logic                    clk,
  input  logic                    rstn,
  input  ime_geom_pkg::ime_cfg_t  cfg_i,
  input  ime_scan_pkg::scan_pos_t pos_i,
  output ime_scan_pkg::ori_port_t ori_o,
  output ime_scan_pkg::ref_port_t ref_o
);

  import ime_geom_pkg::*;
  import ime_scan_pkg::*;

  // mv 0 maps to the middle of the reference memory
  localparam pos_x_t HALF_X = pos_x_t'(1 << (`IME_MV_WIDTH_X - 1));
  localparam pos_y_t HALF_Y = pos_y_t'(1 << (`IME_MV_WIDTH_Y - 1));
  localparam int BLK = `IME_INIT_ROWS;

  pos_x_t    off_x;
  pos_y_t    off_y;
  pos_y_t    off_ini;
  ori_port_t ori_d;
  ref_port_t ref_d;

  assign off_x   = HALF_X + cfg_i.center_x + pos_i.cur_x;
  assign off_y   = HALF_Y + cfg_i.center_y + pos_i.cur_y;
  assign off_ini = HALF_Y + cfg_i.center_y + pos_y_t'(pos_i.init_row);

  always_comb begin
    ori_d = '0;
    ref_d = '0;
    case (pos_i.state)
      ST_INIT: begin
        ori_d.en     = 1'b1;
        ori_d.y      = 6'(pos_i.init_row);
        ref_d.hor_en = 1'b1;
        ref_d.hor_x  = off_x;
        ref_d.hor_y  = off_ini;
      end
      ST_BUSY: begin
        if (pos_i.turn) begin
          // new column enters from the right
          ref_d.dir    = REF_RIGHT;
          ref_d.ver_en = 1'b1;
          ref_d.ver_x  = off_y;
          ref_d.ver_y  = off_x + pos_x_t'(BLK);
        end else begin
          ref_d.dir    = pos_i.dir;
          ref_d.hor_en = 1'b1;
          ref_d.hor_x  = off_x;
          // row just above the block, or just below it
          ref_d.hor_y  = (pos_i.dir == REF_UP) ? off_y - pos_y_t'(1) : off_y + pos_y_t'(BLK);
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ori_o <= '0;
      ref_o <= '0;
    end else begin
      ori_o <= ori_d;
      ref_o <= ref_d;
    end
  end

endmodule

`default_nettype wire

/* ime_mv_cost.sv */
`include "ime_settings.svh"
`default_nettype none

module ime_mv_cost (
  input  logic                    clk,
  input  logic                    rstn,
  input  ime_geom_pkg::ime_cfg_t  cfg_i,
  input  ime_scan_pkg::scan_pos_t pos_i,
  output ime_scan_pkg::mv_stat_t  stat_o
);

  import ime_geom_pkg::*;
  import ime_scan_pkg::*;

  localparam int LAMBDA_W   = 7;
  localparam int BITS_W     = 5;
  localparam int PROD_W     = LAMBDA_W + BITS_W + 1;
  localparam int COST_SHIFT = 8 - `IME_PIXEL_WIDTH;
  localparam logic [`IME_C_MV_WIDTH-1:0] COST_MAX = '1;

  pos_x_t                   sum_x;
  pos_y_t                   sum_y;
  logic [`IME_MV_WIDTH_X:0] abs_x;
  logic [`IME_MV_WIDTH_Y:0] abs_y;
  logic [BITS_W-1:0]        bits_x;
  logic [BITS_W-1:0]        bits_y;
  logic [LAMBDA_W-1:0]      lambda;
  logic [PROD_W-1:0]        cost_raw;
  logic                     busy;
  mv_stat_t                 stat_d;

  // 1 for zero, else 7 plus two per bit above the lsb
  function automatic logic [BITS_W-1:0] mv_bits(input logic [`IME_MV_WIDTH_X:0] a);
    logic [BITS_W-1:0] n;
    n = BITS_W'(1);
    for (int i = 0; i <= `IME_MV_WIDTH_X; i++) begin
      if (a[i]) begin
        n = BITS_W'(7 + 2 * i);
      end
    end
    return n;
  endfunction

  // ------------------------------
  // candidate mv
  // ------------------------------
  assign busy  = (pos_i.state == ST_BUSY);
  assign sum_x = pos_i.cur_x + cfg_i.center_x;
  assign sum_y = pos_i.cur_y + cfg_i.center_y;
  assign abs_x = (sum_x < 0) ? -sum_x : sum_x;
  assign abs_y = (sum_y < 0) ? -sum_y : sum_y;

  assign bits_x = mv_bits(abs_x);
  assign bits_y = mv_bits(($bits(abs_x))'(abs_y));

  // lambda per qp, zero past 51
  always_comb begin
    case (cfg_i.qp) inside
      [6'd0:6'd15]:  lambda = 7'd1;
      [6'd16:6'd19]: lambda = 7'd2;
      [6'd20:6'd22]: lambda = 7'd3;
      [6'd23:6'd25]: lambda = 7'd4;
      6'd26:         lambda = 7'd5;
      6'd27, 6'd28:  lambda = 7'd6;
      6'd29:         lambda = 7'd7;
      6'd30:         lambda = 7'd8;
      6'd31:         lambda = 7'd9;
      6'd32:         lambda = 7'd10;
      6'd33:         lambda = 7'd11;
      6'd34:         lambda = 7'd13;
      6'd35:         lambda = 7'd14;
      6'd36:         lambda = 7'd16;
      6'd37:         lambda = 7'd18;
      6'd38:         lambda = 7'd20;
      6'd39:         lambda = 7'd23;
      6'd40:         lambda = 7'd25;
      6'd41:         lambda = 7'd29;
      6'd42:         lambda = 7'd32;
      6'd43:         lambda = 7'd36;
      6'd44:         lambda = 7'd40;
      6'd45:         lambda = 7'd45;
      6'd46:         lambda = 7'd51;
      6'd47:         lambda = 7'd57;
      6'd48:         lambda = 7'd64;
      6'd49:         lambda = 7'd72;
      6'd50:         lambda = 7'd81;
      6'd51:         lambda = 7'd91;
      default:       lambda = 7'd0;
    endcase
  end

  assign cost_raw = (lambda * (bits_x + bits_y)) >> COST_SHIFT;

  // ------------------------------
  // status register
  // ------------------------------
  always_comb begin
    stat_d = '0;
    if (busy) begin
      stat_d.valid = 1'b1;
      stat_d.mv_x  = mv_x_t'(sum_x);
      stat_d.mv_y  = mv_y_t'(sum_y);
      stat_d.cost  = (cost_raw > COST_MAX) ? COST_MAX : cost_raw[`IME_C_MV_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stat_o <= '0;
    end else begin
      stat_o <= stat_d;
    end
  end

endmodule

`default_nettype wire

/* ime_addressing.sv */
`default_nettype none

module ime_addressing (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start_i,
  input  ime_geom_pkg::ime_cfg_t  cfg_i,
  output logic                    done_o,
  output ime_scan_pkg::ori_port_t ori_o,
  output ime_scan_pkg::ref_port_t ref_o,
  output ime_scan_pkg::mv_stat_t  stat_o
);

  import ime_geom_pkg::*;
  import ime_scan_pkg::*;

  ime_cfg_t  cfg_held;
  scan_pos_t scan_pos;
  logic      idle;

  ime_cfg_regs u_cfg_regs (
    .clk     (clk),
    .rstn    (rstn),
    .start_i (start_i),
    .idle_i  (idle),
    .cfg_i   (cfg_i),
    .cfg_o   (cfg_held)
  );

  ime_scan_ctrl u_scan_ctrl (
    .clk     (clk),
    .rstn    (rstn),
    .start_i (start_i),
    .cfg_i   (cfg_held),
    .idle_o  (idle),
    .pos_o   (scan_pos),
    .done_o  (done_o)
  );

  // both consumers see the same position and register one cycle later
  ime_ref_addr u_ref_addr (
    .clk   (clk),
    .rstn  (rstn),
    .cfg_i (cfg_held),
    .pos_i (scan_pos),
    .ori_o (ori_o),
    .ref_o (ref_o)
  );

  ime_mv_cost u_mv_cost (
    .clk    (clk),
    .rstn   (rstn),
    .cfg_i  (cfg_held),
    .pos_i  (scan_pos),
    .stat_o (stat_o)
  );

endmodule

`default_nettype wire

/* ime_addressing_checker.sv */
`default_nettype none

module ime_addressing_checker (
  input logic                    clk,
  input logic                    rstn,
  input logic                    done_i,
  input ime_scan_pkg::ori_port_t ori_i,
  input ime_scan_pkg::ref_port_t ref_i,
  input ime_scan_pkg::mv_stat_t  stat_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // set once the matching assertion has failed
  logic done_bad = 1'b0;
  logic port_bad = 1'b0;
  logic excl_bad = 1'b0;
  logic failed;

  assign failed = done_bad || port_bad || excl_bad;

  // done is a single-cycle pulse
  done_single: assert property (@(posedge clk) disable iff (!rstn) done_i |=> !done_i)
    else begin
      done_bad = 1'b1;
      $error("done stayed high for two cycles");
    end

  // one ref port per cycle
  ref_ports_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(ref_i.hor_en && ref_i.ver_en))
    else begin
      port_bad = 1'b1;
      $error("horizontal and vertical ref ports enabled together");
    end

  // init and search never overlap
  ori_valid_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(ori_i.en && stat_i.valid))
    else begin
      excl_bad = 1'b1;
      $error("ori enable and mv valid high together");
    end

endmodule

bind ime_addressing ime_addressing_checker u_checker (
  .clk    (clk),
  .rstn   (rstn),
  .done_i (done_o),
  .ori_i  (ori_o),
  .ref_i  (ref_o),
  .stat_i (stat_o)
);

`default_nettype wire

/* tb_ime_addressing.sv */
`include "ime_settings.svh"
`default_nettype none

module tb_ime_addressing;

  timeunit 1ns;
  timeprecision 1ps;

  import ime_geom_pkg::*;
  import ime_scan_pkg::*;

  // one search setup with the expected first and last mv x
  typedef struct packed {
    int cx;
    int cy;
    int lx;
    int ly;
    int slope;
    int qp;
    int first_x;
    int last_x;
  } row_t;

  logic      clk;
  logic      rstn;
  logic      start_i;
  ime_cfg_t  cfg_i;
  logic      done_o;
  ori_port_t ori_o;
  ref_port_t ref_o;
  mv_stat_t  stat_o;

  row_t rows [8];
  int   exp_x[$];
  int   exp_y[$];
  int   exp_turn[$];
  int   exp_dir[$];

  // lambda per qp 0..51 and zero above
  int lambda_tab [52] = '{
    1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1,
    2, 2, 2, 2, 3, 3, 3, 4, 4, 4, 5, 6, 6, 7, 8, 9,
    10, 11, 13, 14, 16, 18, 20, 23, 25, 29, 32, 36, 40, 45, 51, 57,
    64, 72, 81, 91
  };

  ime_addressing dut_i (
    .clk     (clk),
    .rstn    (rstn),
    .start_i (start_i),
    .cfg_i   (cfg_i),
    .done_o  (done_o),
    .ori_o   (ori_o),
    .ref_o   (ref_o),
    .stat_o  (stat_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  // bound assertions on the DUT outputs
  always @(negedge clk) begin
    if (dut_i.u_checker.failed) begin
      stop_on_error("A bound assertion on the DUT outputs failed");
    end
  end

  function automatic int abs_int(input int a);
    return (a < 0) ? -a : a;
  endfunction

  // y edge of the slope pattern for column x
  function automatic int slope_edge(input row_t r, input int x);
    int d;
    d = r.lx - abs_int(x);
    case (r.slope)
      0: return d >>> 1;
      1: return d;
      2: return d * 2;
      default: return r.ly;
    endcase
  endfunction

  function automatic int bit_count(input int a);
    int n;
    int v;
    if (a == 0) begin
      return 1;
    end
    n = 7;
    v = a;
    while (v > 1) begin
      v = v >> 1;
      n = n + 2;
    end
    return n;
  endfunction

  function automatic int expected_cost(input int qp, input int mx, input int my);
    int lam;
    int c;
    lam = (qp <= 51) ? lambda_tab[qp] : 0;
    c = lam * (bit_count(abs_int(mx)) + bit_count(abs_int(my)));
    return (c > 1023) ? 1023 : c;
  endfunction

  // reference snake walk over the search pattern
  task automatic build_walk(input row_t r);
    int x;
    int y;
    int dir;
    int lim;
    bit at_y;
    bit at_x;
    exp_x.delete();
    exp_y.delete();
    exp_turn.delete();
    exp_dir.delete();
    x = (-60 - r.cx > -r.lx) ? -60 - r.cx : -r.lx;
    y = 0;
    dir = 0;
    for (int n = 0; n < 20000; n++) begin
      lim = slope_edge(r, x);
      if (dir == 1) begin
        at_y = (y <= -28 - r.cy) || (y <= -r.ly) || (y <= -lim);
      end else begin
        at_y = (y >= 28 - r.cy) || (y >= r.ly) || (y >= lim);
      end
      at_x = (x >= 60 - r.cx) || (x >= r.lx);
      exp_x.push_back(x);
      exp_y.push_back(y);
      exp_turn.push_back(int'(at_y));
      exp_dir.push_back(dir);
      if (at_x && at_y) begin
        break;
      end
      if (at_y) begin
        x = x + 1;
        dir = 1 - dir;
      end else begin
        y = (dir == 1) ? y - 1 : y + 1;
      end
    end
  endtask

  task automatic check_point(input row_t r, input int k, input bit last);
    int x;
    int y;
    int ox;
    int oy;
    int dx;
    int dy;
    int edge_y;
    x = exp_x[k];
    y = exp_y[k];
    ox = 64 + r.cx + x;
    oy = 32 + r.cy + y;
    assert (stat_o.valid && int'(stat_o.mv_x) == r.cx + x && int'(stat_o.mv_y) == r.cy + y)
      else stop_on_error($sformatf(
        "Error at %0t ns: point %0d mv (%0d,%0d) valid %0b, exp (%0d,%0d)",
        $time, k, stat_o.mv_x, stat_o.mv_y, stat_o.valid, r.cx + x, r.cy + y));
    assert (int'(stat_o.cost) == expected_cost(r.qp, r.cx + x, r.cy + y))
      else stop_on_error($sformatf("Error at %0t ns: point %0d cost %0d, exp %0d", $time, k,
        stat_o.cost, expected_cost(r.qp, r.cx + x, r.cy + y)));
    assert (done_o == last)
      else stop_on_error($sformatf("Error at %0t ns: point %0d done %0b", $time, k, done_o));
    if (exp_turn[k] != 0) begin
      assert (ref_o.ver_en && !ref_o.hor_en && ref_o.dir == REF_RIGHT
              && int'(ref_o.ver_x) == (oy & 127) && int'(ref_o.ver_y) == ((ox + 32) & 255))
        else stop_on_error($sformatf("Error at %0t ns: point %0d vertical ref port wrong",
          $time, k));
    end else begin
      assert (ref_o.hor_en && !ref_o.ver_en && int'(ref_o.dir) == exp_dir[k]
              && int'(ref_o.hor_x) == (ox & 255)
              && int'(ref_o.hor_y) == (((exp_dir[k] == 1) ? oy - 1 : oy + 32) & 127))
        else stop_on_error($sformatf("Error at %0t ns: point %0d horizontal ref port wrong",
          $time, k));
    end
    // search offset of the mv the DUT reported
    dx = int'(stat_o.mv_x) - r.cx;
    dy = int'(stat_o.mv_y) - r.cy;
    // a turn keeps the y of the column it leaves
    edge_y = slope_edge(r, dx);
    if (slope_edge(r, dx - 1) > edge_y) begin
      edge_y = slope_edge(r, dx - 1);
    end
    assert (abs_int(int'(stat_o.mv_x)) <= 60 && abs_int(int'(stat_o.mv_y)) <= 28
            && abs_int(dx) <= r.lx && abs_int(dy) <= r.ly
            && abs_int(dy) <= ((edge_y > 0) ? edge_y : 0))
      else stop_on_error($sformatf("Error at %0t ns: point %0d (%0d,%0d) out of bounds",
        $time, k, dx, dy));
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   cnt;
    r = rows[idx];
    build_walk(r);
    assert (r.cx + exp_x[0] == r.first_x && r.cx + exp_x[exp_x.size() - 1] == r.last_x)
      else stop_on_error($sformatf("Error at %0t ns: row %0d table first/last x disagree",
        $time, idx));
    cfg_i.center_x = mv_x_t'(r.cx);
    cfg_i.center_y = mv_y_t'(r.cy);
    cfg_i.len_x    = len_x_t'(r.lx);
    cfg_i.len_y    = len_y_t'(r.ly);
    cfg_i.slope    = slope_e'(r.slope);
    cfg_i.qp       = 6'(r.qp);
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    // inputs may move once the start is taken
    cfg_i = ime_cfg_t'($urandom());
    cnt = 0;
    while (!ori_o.en) begin
      @(negedge clk);
      cnt++;
      if (cnt > 50) begin
        stop_on_error($sformatf("Timeout: row %0d ori enable never rose", idx));
      end
    end
    for (int k = 0; k < 32; k++) begin
      assert (ori_o.en && int'(ori_o.y) == k && ori_o.x == 6'd0 && ref_o.hor_en
              && ref_o.dir == REF_DOWN && int'(ref_o.hor_x) == ((64 + r.first_x) & 255)
              && int'(ref_o.hor_y) == ((32 + r.cy + k) & 127))
        else stop_on_error($sformatf("Error at %0t ns: init row %0d ports wrong", $time, k));
      @(negedge clk);
    end
    assert (!ori_o.en)
      else stop_on_error($sformatf("Error at %0t ns: ori enable longer than 32", $time));
    cnt = 0;
    while (!stat_o.valid) begin
      @(negedge clk);
      cnt++;
      if (cnt > 50) begin
        stop_on_error($sformatf("Timeout: row %0d no valid mv after init", idx));
      end
    end
    for (int k = 0; k < exp_x.size(); k++) begin
      check_point(r, k, k == exp_x.size() - 1);
      // a start while busy must be ignored
      if (idx == 1 && k == 5) begin
        start_i = 1'b1;
        cfg_i = ime_cfg_t'($urandom());
      end
      @(negedge clk);
      start_i = 1'b0;
    end
    assert (!stat_o.valid && !done_o)
      else stop_on_error($sformatf("Error at %0t ns: run did not end cleanly", $time));
  endtask

  initial begin
    int unsigned seed;
    int          cx;
    int          cy;
    int          lx;
    seed = $urandom(46150);
    start_i = 1'b0;
    cfg_i   = '0;
    rstn    = 1'b0;

    rows[0] = '{0, 0, 4, 3, 3, 20, -4, 4};
    rows[1] = '{5, -3, 6, 5, 1, 30, -1, 11};
    rows[2] = '{-10, 2, 8, 4, 0, 51, -18, -2};
    rows[3] = '{58, 0, 6, 4, 2, 40, 52, 60};
    rows[4] = '{-57, -25, 5, 6, 1, 10, -60, -52};
    rows[5] = '{3, 20, 10, 10, 3, 63, -7, 13};
    // saturates the cost
    rows[6] = '{0, 0, 31, 31, 2, 51, -31, 31};
    cx = int'($urandom_range(40)) - 20;
    cy = int'($urandom_range(20)) - 10;
    lx = int'($urandom_range(11)) + 1;
    rows[7] = '{cx, cy, lx, int'($urandom_range(7)) + 1, int'($urandom_range(3)),
                int'($urandom_range(63)), cx + ((-60 - cx > -lx) ? -60 - cx : -lx),
                cx + ((60 - cx < lx) ? 60 - cx : lx)};

    repeat (16) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    assert (!done_o && !stat_o.valid && !ori_o.en && !ref_o.hor_en && !ref_o.ver_en
            && ref_o.dir == REF_DOWN)
      else stop_on_error($sformatf("Error at %0t ns: outputs active after reset", $time));

    for (int i = 0; i < 8; i++) begin
      run_row(i);
      repeat (3) @(negedge clk);
    end

    if (!dut_i.u_checker.failed) begin
      $display("PASS: all tests");
    end else begin
      stop_on_error("A bound assertion on the DUT outputs failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
ime_geom_pkg.sv
ime_scan_pkg.sv
ime_cfg_regs.sv
ime_scan_ctrl.sv
ime_ref_addr.sv
ime_mv_cost.sv
ime_addressing.sv
ime_addressing_checker.sv
tb_ime_addressing.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_ime_addressing -f sim.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1
